/* verilog/rrPkg.sv */
// Sizes shared by every block of the two-lane register-read stage
// Imported by each RTL module and used by the testbench for its models

package rrPkg;

  // Issue width
  localparam int NUM_LANES = 2;  // Issue lanes, one result bus each
  localparam int NUM_SRCS  = 2;  // Source operands per instruction
  localparam int RD_PORTS  = NUM_LANES * NUM_SRCS;

  // Physical register file
  localparam int PHYS_REGS  = 64;
  localparam int PHYS_TAG_W = 6;
  localparam int DATA_W     = 32;

  // Branch checkpoints
  localparam int CHECKPOINTS     = 4;  // Also the mask width
  localparam int CHECKPOINT_ID_W = 2;

  // Registers holding committed architectural state after reset
  localparam int ARCH_REGS = 32;

  localparam int ISSUE_TAG_W = 8;  // Opaque, passed through

  // Ready pattern restored on reset and on an exception
  localparam logic [PHYS_REGS-1:0] RDY_INIT = {
    {(PHYS_REGS - ARCH_REGS){1'b0}},
    {ARCH_REGS{1'b1}}
  };

endpackage

/* verilog/physRegFile.sv */
`timescale 1ns/1ns
// Physical register file with one read pair and one write port per issue lane
// Reads are registered, so a write at an edge is seen by a read issued next cycle

module physRegFile (
  input  logic                                                clk,
  input  logic                                                arstN_i,
  input  logic [rrPkg::RD_PORTS-1:0][rrPkg::PHYS_TAG_W-1:0]   rdTag_i,
  input  logic [rrPkg::NUM_LANES-1:0]                         wrValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]  wrTag_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::DATA_W-1:0]      wrData_i,
  input  logic                                                recoverFlag_i,
  output logic [rrPkg::RD_PORTS-1:0][rrPkg::DATA_W-1:0]       rdData_o
);
  import rrPkg::*;

  logic [DATA_W-1:0] regMem [PHYS_REGS];

  // Lanes walked upward so the higher lane lands last on a conflict
  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wrValid_i[l] && !recoverFlag_i) begin  // Dropped during recovery
        regMem[wrTag_i[l]] <= wrData_i[l];
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      rdData_o <= '0;
    end else begin
      for (int p = 0; p < RD_PORTS; p++) begin
        rdData_o[p] <= regMem[rdTag_i[p]];  // Old contents on same-edge write
      end
    end
  end

endmodule

/* verilog/operandBypass.sv */
`timescale 1ns/1ns
// Forwarding for the two sources of one lane
// Matches against this cycle's result buses are held for a cycle and then
// picked over the registered register-file data

module operandBypass (
  input  logic                                                clk,
  input  logic                                                arstN_i,
  input  logic [rrPkg::PHYS_TAG_W-1:0]                        src1Tag_i,
  input  logic [rrPkg::PHYS_TAG_W-1:0]                        src2Tag_i,
  input  logic [rrPkg::NUM_LANES-1:0]                         resultValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]  resultTag_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::DATA_W-1:0]      resultData_i,
  input  logic [rrPkg::DATA_W-1:0]                            rf1Data_i,
  input  logic [rrPkg::DATA_W-1:0]                            rf2Data_i,
  output logic [rrPkg::DATA_W-1:0]                            operand1_o,
  output logic [rrPkg::DATA_W-1:0]                            operand2_o
);
  import rrPkg::*;

  logic [NUM_SRCS-1:0][PHYS_TAG_W-1:0] srcTag;
  logic [NUM_SRCS-1:0]                 hitD;
  logic [NUM_SRCS-1:0]                 hitQ;
  logic [NUM_SRCS-1:0][DATA_W-1:0]     fwdD;
  logic [NUM_SRCS-1:0][DATA_W-1:0]     fwdQ;

  assign srcTag = {src2Tag_i, src1Tag_i};

  always_comb begin
    hitD = '0;
    fwdD = '0;
    for (int s = 0; s < NUM_SRCS; s++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (resultValid_i[l] && (resultTag_i[l] == srcTag[s])) begin
          hitD[s] = 1'b1;
          fwdD[s] = resultData_i[l];  // Higher lane overrides
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      hitQ <= '0;
    end else begin
      hitQ <= hitD;
    end
  end

  always_ff @(posedge clk) begin
    fwdQ <= fwdD;
  end

  // Second half of the stage
  assign operand1_o = hitQ[0] ? fwdQ[0] : rf1Data_i;
  assign operand2_o = hitQ[1] ? fwdQ[1] : rf2Data_i;

endmodule

/* verilog/issueSquash.sv */
`timescale 1ns/1ns
// Kills issued instructions that sit under a resolved mispredicted branch,
// then registers valid and issue tag for all lanes

module issueSquash (
  input  logic                                                 clk,
  input  logic                                                 arstN_i,
  input  logic [rrPkg::NUM_LANES-1:0]                          issueValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::CHECKPOINTS-1:0]  ckptMask_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::ISSUE_TAG_W-1:0]  issueTag_i,
  input  logic                                                 ctrlVerified_i,
  input  logic                                                 ctrlMispredict_i,
  input  logic [rrPkg::CHECKPOINT_ID_W-1:0]                    ctrlCkptId_i,
  output logic [rrPkg::NUM_LANES-1:0]                          opValid_o,
  output logic [rrPkg::NUM_LANES-1:0][rrPkg::ISSUE_TAG_W-1:0]  opIssueTag_o
);
  import rrPkg::*;

  logic                 mispredict;
  logic [NUM_LANES-1:0] squash;

  assign mispredict = ctrlVerified_i && ctrlMispredict_i;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      squash[l] = mispredict && ckptMask_i[l][ctrlCkptId_i];  // Depends on that branch
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      opValid_o <= '0;
    end else begin
      opValid_o <= issueValid_i & ~squash;
    end
  end

  always_ff @(posedge clk) begin
    opIssueTag_o <= issueTag_i;
  end

endmodule

/* verilog/readyScoreboard.sv */
`timescale 1ns/1ns
// Ready bit per physical register for the issue logic
// Unmaps clear bits, wakeups set them; reset and exceptions reload the
// architectural pattern

module readyScoreboard (
  input  logic                                                clk,
  input  logic                                                arstN_i,
  input  logic                                                exceptionFlag_i,
  input  logic [rrPkg::NUM_LANES-1:0]                         unmapValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]  unmapTag_i,
  input  logic [rrPkg::NUM_LANES-1:0]                         wakeupValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]  wakeupTag_i,
  output logic [rrPkg::PHYS_REGS-1:0]                         phyRegRdy_o
);
  import rrPkg::*;

  logic [PHYS_REGS-1:0] rdyNext;

  always_comb begin
    rdyNext = phyRegRdy_o;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        rdyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    // Sets applied after clears so a wakeup wins
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeupValid_i[l]) begin
        rdyNext[wakeupTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      phyRegRdy_o <= RDY_INIT;
    end else if (exceptionFlag_i) begin
      phyRegRdy_o <= RDY_INIT;  // Back to committed mapping
    end else begin
      phyRegRdy_o <= rdyNext;
    end
  end

endmodule

/* verilog/regReadStage.sv */
`timescale 1ns/1ns
// Register-read stage for two issue lanes: operand read with forwarding,
// mispredict squash and the ready scoreboard. Operands and valids leave one
// cycle after issue

module regReadStage (
  input  logic                                                 clk,
  input  logic                                                 arstN_i,
  input  logic [rrPkg::NUM_LANES-1:0]                          issueValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]   src1Tag_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]   src2Tag_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::CHECKPOINTS-1:0]  ckptMask_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::ISSUE_TAG_W-1:0]  issueTag_i,
  input  logic [rrPkg::NUM_LANES-1:0]                          resultValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]   resultTag_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::DATA_W-1:0]       resultData_i,
  input  logic                                                 recoverFlag_i,
  input  logic                                                 exceptionFlag_i,
  input  logic                                                 ctrlVerified_i,
  input  logic                                                 ctrlMispredict_i,
  input  logic [rrPkg::CHECKPOINT_ID_W-1:0]                    ctrlCkptId_i,
  input  logic [rrPkg::NUM_LANES-1:0]                          unmapValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]   unmapTag_i,
  input  logic [rrPkg::NUM_LANES-1:0]                          wakeupValid_i,
  input  logic [rrPkg::NUM_LANES-1:0][rrPkg::PHYS_TAG_W-1:0]   wakeupTag_i,
  output logic [rrPkg::NUM_LANES-1:0]                          opValid_o,
  output logic [rrPkg::NUM_LANES-1:0][rrPkg::DATA_W-1:0]       operand1_o,
  output logic [rrPkg::NUM_LANES-1:0][rrPkg::DATA_W-1:0]       operand2_o,
  output logic [rrPkg::NUM_LANES-1:0][rrPkg::ISSUE_TAG_W-1:0]  opIssueTag_o,
  output logic [rrPkg::PHYS_REGS-1:0]                          phyRegRdy_o
);
  import rrPkg::*;

  logic [RD_PORTS-1:0][PHYS_TAG_W-1:0] rfRdTag;
  logic [RD_PORTS-1:0][DATA_W-1:0]     rfRdData;

  physRegFile u_physRegFile (
    .clk           (clk),
    .arstN_i       (arstN_i),
    .rdTag_i       (rfRdTag),
    .wrValid_i     (resultValid_i),  // Each lane owns its write port
    .wrTag_i       (resultTag_i),
    .wrData_i      (resultData_i),
    .recoverFlag_i (recoverFlag_i),
    .rdData_o      (rfRdData)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : gLane
    assign rfRdTag[NUM_SRCS*g]     = src1Tag_i[g];
    assign rfRdTag[NUM_SRCS*g + 1] = src2Tag_i[g];

    operandBypass u_operandBypass (
      .clk           (clk),
      .arstN_i       (arstN_i),
      .src1Tag_i     (src1Tag_i[g]),
      .src2Tag_i     (src2Tag_i[g]),
      .resultValid_i (resultValid_i),
      .resultTag_i   (resultTag_i),
      .resultData_i  (resultData_i),
      .rf1Data_i     (rfRdData[NUM_SRCS*g]),
      .rf2Data_i     (rfRdData[NUM_SRCS*g + 1]),
      .operand1_o    (operand1_o[g]),
      .operand2_o    (operand2_o[g])
    );
  end

  issueSquash u_issueSquash (
    .clk              (clk),
    .arstN_i          (arstN_i),
    .issueValid_i     (issueValid_i),
    .ckptMask_i       (ckptMask_i),
    .issueTag_i       (issueTag_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlMispredict_i (ctrlMispredict_i),
    .ctrlCkptId_i     (ctrlCkptId_i),
    .opValid_o        (opValid_o),
    .opIssueTag_o     (opIssueTag_o)
  );

  readyScoreboard u_readyScoreboard (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmapValid_i    (unmapValid_i),
    .unmapTag_i      (unmapTag_i),
    .wakeupValid_i   (wakeupValid_i),
    .wakeupTag_i     (wakeupTag_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

/* sim/regReadTests.svh */
// Directed tests for the register-read stage, included in the testbench body
// Each task starts at a falling edge, drives inputs and calls stepCycle,
// which checks outputs against the models one cycle later

`ifndef REG_READ_TESTS_SVH
`define REG_READ_TESTS_SVH

task automatic checkResetState();
  testName = "checkResetState";
  if (phyRegRdy !== initialReady()) begin
    reportMismatch("phyRegRdy", 64'(initialReady()), 64'(phyRegRdy));
  end
  if (opValid !== '0) reportMismatch("opValid", 64'(0), 64'(opValid));
endtask

// Register contents are not reset, so give every entry a known value
task automatic preloadRegs();
  testName = "preloadRegs";
  for (int r = 0; r < PHYS_REGS; r += 2) begin
    resultBus(0, PHYS_TAG_W'(r), nextRand());
    resultBus(1, PHYS_TAG_W'(r + 1), nextRand());
    stepCycle();
  end
endtask

task automatic writeThenRead();
  testName = "writeThenRead";
  resultBus(0, 6'd10, nextRand());
  resultBus(1, 6'd45, nextRand());
  stepCycle();
  issueLane(0, 6'd10, 6'd45, 4'b0000, 8'h11);
  issueLane(1, 6'd45, 6'd10, 4'b0000, 8'h12);
  stepCycle();
  // Writes during recovery are dropped
  recoverFlag = 1'b1;
  resultBus(0, 6'd10, nextRand());
  resultBus(1, 6'd45, nextRand());
  stepCycle();
  issueLane(0, 6'd10, 6'd45, 4'b0000, 8'h13);
  issueLane(1, 6'd45, 6'd10, 4'b0000, 8'h14);
  stepCycle();
endtask

task automatic sameCycleForward();
  testName = "sameCycleForward";
  resultBus(0, 6'd20, nextRand());
  resultBus(1, 6'd33, nextRand());
  issueLane(0, 6'd20, 6'd33, 4'b0000, 8'h21);
  issueLane(1, 6'd33, 6'd5, 4'b0000, 8'h22);
  stepCycle();
  resultBus(0, 6'd50, nextRand());  // Both buses name one register
  resultBus(1, 6'd50, nextRand());
  issueLane(0, 6'd50, 6'd50, 4'b0000, 8'h23);
  issueLane(1, 6'd7, 6'd50, 4'b0000, 8'h24);
  stepCycle();
  issueLane(0, 6'd50, 6'd20, 4'b0000, 8'h25);
  stepCycle();
  recoverFlag = 1'b1;  // Forwarding still applies
  resultBus(0, 6'd60, nextRand());
  issueLane(1, 6'd60, 6'd60, 4'b0000, 8'h26);
  stepCycle();
endtask

task automatic mispredictSquash();
  testName = "mispredictSquash";
  ctrlVerified   = 1'b1;
  ctrlMispredict = 1'b1;
  ctrlCkptId     = 2'd2;
  issueLane(0, 6'd1, 6'd2, 4'b0100, 8'h31);
  issueLane(1, 6'd3, 6'd4, 4'b1011, 8'h32);
  stepCycle();
  if (opValid !== 2'b10) reportMismatch("squashed opValid", 64'(2'b10), 64'(opValid));
  // Unverified branch kills nothing
  ctrlMispredict = 1'b1;
  ctrlCkptId     = 2'd2;
  issueLane(0, 6'd5, 6'd6, 4'b0100, 8'h33);
  issueLane(1, 6'd7, 6'd8, 4'b0100, 8'h34);
  stepCycle();
  ctrlVerified   = 1'b1;
  ctrlMispredict = 1'b1;
  ctrlCkptId     = 2'd3;
  issueLane(0, 6'd9, 6'd10, 4'b1000, 8'h35);
  issueLane(1, 6'd11, 6'd12, 4'b0111, 8'h36);
  stepCycle();
endtask

task automatic scoreboardUpdates();
  testName = "scoreboardUpdates";
  unmapValid = 2'b11;
  unmapTag   = {6'd12, 6'd3};
  stepCycle();
  wakeupValid = 2'b11;
  wakeupTag   = {6'd50, 6'd3};
  stepCycle();
  unmapValid[0]  = 1'b1;  // Clear and set of one register
  unmapTag[0]    = 6'd9;
  wakeupValid[1] = 1'b1;
  wakeupTag[1]   = 6'd9;
  stepCycle();
  if (phyRegRdy[9] !== 1'b1) reportMismatch("ready bit 9", 64'(1), 64'(phyRegRdy[9]));
  exceptionFlag = 1'b1;
  unmapValid    = 2'b01;
  unmapTag[0]   = 6'd4;
  stepCycle();
  if (phyRegRdy !== initialReady()) begin
    reportMismatch("ready after exception", 64'(initialReady()), 64'(phyRegRdy));
  end
endtask

task automatic backToBackIssue();
  logic [31:0] r;
  logic [31:0] w;
  testName = "backToBackIssue";
  for (int c = 0; c < RAND_CYCLES; c++) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      r = nextRand();
      w = nextRand();
      issueLane(l, r[5:0], {2'b00, r[9:6]}, r[13:10], r[21:14]);
      if (w[0]) resultBus(l, {2'b00, w[4:1]}, nextRand());  // Narrow tags to hit often
      unmapValid[l]  = w[8];
      unmapTag[l]    = w[14:9];
      wakeupValid[l] = w[15];
      wakeupTag[l]   = w[21:16];
    end
    r = nextRand();
    ctrlVerified   = r[0];
    ctrlMispredict = r[1];
    ctrlCkptId     = r[3:2];
    recoverFlag    = (r[7:4] == 4'd0);
    exceptionFlag  = (r[12:8] == 5'd0);
    stepCycle();
  end
endtask

`endif

/* sim/regReadTb.sv */
`timescale 1ns/1ns
// Testbench for the two-lane register-read stage
// Holds clock, reset, the DUT, reference models for register contents and
// ready bits, and a watchdog; the directed tests are included below

module regReadTb;
  import rrPkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_CYCLES  = 120;
  localparam int TEST_COUNT   = 7;    // Preload plus six directed tests
  localparam int CYCLE_BUDGET = 200;  // Generous bound per test
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_COUNT * CYCLE_BUDGET) * CLK_PERIOD;

  logic                                    clk = 1'b0;
  logic                                    arstN;
  logic [NUM_LANES-1:0]                    issueValid;
  logic [NUM_LANES-1:0][PHYS_TAG_W-1:0]    src1Tag;
  logic [NUM_LANES-1:0][PHYS_TAG_W-1:0]    src2Tag;
  logic [NUM_LANES-1:0][CHECKPOINTS-1:0]   ckptMask;
  logic [NUM_LANES-1:0][ISSUE_TAG_W-1:0]   issueTag;
  logic [NUM_LANES-1:0]                    resultValid;
  logic [NUM_LANES-1:0][PHYS_TAG_W-1:0]    resultTag;
  logic [NUM_LANES-1:0][DATA_W-1:0]        resultData;
  logic                                    recoverFlag;
  logic                                    exceptionFlag;
  logic                                    ctrlVerified;
  logic                                    ctrlMispredict;
  logic [CHECKPOINT_ID_W-1:0]              ctrlCkptId;
  logic [NUM_LANES-1:0]                    unmapValid;
  logic [NUM_LANES-1:0][PHYS_TAG_W-1:0]    unmapTag;
  logic [NUM_LANES-1:0]                    wakeupValid;
  logic [NUM_LANES-1:0][PHYS_TAG_W-1:0]    wakeupTag;
  logic [NUM_LANES-1:0]                    opValid;
  logic [NUM_LANES-1:0][DATA_W-1:0]        operand1;
  logic [NUM_LANES-1:0][DATA_W-1:0]        operand2;
  logic [NUM_LANES-1:0][ISSUE_TAG_W-1:0]   opIssueTag;
  logic [PHYS_REGS-1:0]                    phyRegRdy;

  logic [DATA_W-1:0]    refMem [PHYS_REGS];  // Expected register contents
  logic [PHYS_REGS-1:0] refRdy;
  logic [31:0]          lcgState   = 32'h93c1;
  string                testName   = "reset";
  int                   errorCount = 0;
  int                   cycleCount = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  regReadStage u_dut (
    .clk              (clk),
    .arstN_i          (arstN),
    .issueValid_i     (issueValid),
    .src1Tag_i        (src1Tag),
    .src2Tag_i        (src2Tag),
    .ckptMask_i       (ckptMask),
    .issueTag_i       (issueTag),
    .resultValid_i    (resultValid),
    .resultTag_i      (resultTag),
    .resultData_i     (resultData),
    .recoverFlag_i    (recoverFlag),
    .exceptionFlag_i  (exceptionFlag),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCkptId_i     (ctrlCkptId),
    .unmapValid_i     (unmapValid),
    .unmapTag_i       (unmapTag),
    .wakeupValid_i    (wakeupValid),
    .wakeupTag_i      (wakeupTag),
    .opValid_o        (opValid),
    .operand1_o       (operand1),
    .operand2_o       (operand2),
    .opIssueTag_o     (opIssueTag),
    .phyRegRdy_o      (phyRegRdy)
  );

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState ^ (lcgState >> 16);  // Low state bits repeat quickly
  endfunction

  // Low registers hold committed state, the rest wait for a producer
  function automatic logic [PHYS_REGS-1:0] initialReady();
    logic [PHYS_REGS-1:0] rdy;
    for (int r = 0; r < PHYS_REGS; r++) begin
      rdy[r] = (r < ARCH_REGS);
    end
    return rdy;
  endfunction

  function automatic logic [DATA_W-1:0] expectedOperand(input logic [PHYS_TAG_W-1:0] tag);
    logic [DATA_W-1:0] val;
    val = refMem[tag];
    for (int l = 0; l < NUM_LANES; l++) begin
      if (resultValid[l] && resultTag[l] == tag) begin
        val = resultData[l];  // Later lane has priority
      end
    end
    return val;
  endfunction

  task automatic reportMismatch(input string what, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    errorCount++;
    $display("FAIL %s %s: expected %h actual %h", testName, what, expVal, actVal);
  endtask

  task automatic idleInputs();
    issueValid     = '0;
    src1Tag        = '0;
    src2Tag        = '0;
    ckptMask       = '0;
    issueTag       = '0;
    resultValid    = '0;
    resultTag      = '0;
    resultData     = '0;
    recoverFlag    = 1'b0;
    exceptionFlag  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCkptId     = '0;
    unmapValid     = '0;
    unmapTag       = '0;
    wakeupValid    = '0;
    wakeupTag      = '0;
  endtask

  task automatic issueLane(input int lane, input logic [PHYS_TAG_W-1:0] s1,
                           input logic [PHYS_TAG_W-1:0] s2,
                           input logic [CHECKPOINTS-1:0] mask,
                           input logic [ISSUE_TAG_W-1:0] tag);
    issueValid[lane] = 1'b1;
    src1Tag[lane]    = s1;
    src2Tag[lane]    = s2;
    ckptMask[lane]   = mask;
    issueTag[lane]   = tag;
  endtask

  task automatic resultBus(input int lane, input logic [PHYS_TAG_W-1:0] tag,
                           input logic [DATA_W-1:0] data);
    resultValid[lane] = 1'b1;
    resultTag[lane]   = tag;
    resultData[lane]  = data;
  endtask

  // Model state as it stands right after a clock edge
  task automatic updateModel();
    for (int l = 0; l < NUM_LANES; l++) begin
      if (resultValid[l] && !recoverFlag) begin
        refMem[resultTag[l]] = resultData[l];
      end
    end
    if (exceptionFlag) begin
      refRdy = initialReady();
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (unmapValid[l]) refRdy[unmapTag[l]] = 1'b0;
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wakeupValid[l]) refRdy[wakeupTag[l]] = 1'b1;
      end
    end
  endtask

  // One clock with the inputs set at this falling edge, checked at the next
  task automatic stepCycle();
    logic [NUM_LANES-1:0]                  issued;
    logic [NUM_LANES-1:0]                  expValid;
    logic [NUM_LANES-1:0][DATA_W-1:0]      expOp1;
    logic [NUM_LANES-1:0][DATA_W-1:0]      expOp2;
    logic [NUM_LANES-1:0][ISSUE_TAG_W-1:0] expTag;
    logic                                  mispredict;
    issued     = issueValid;
    mispredict = ctrlVerified && ctrlMispredict;
    for (int l = 0; l < NUM_LANES; l++) begin
      expValid[l] = issueValid[l] && !(mispredict && ckptMask[l][ctrlCkptId]);
      expOp1[l]   = expectedOperand(src1Tag[l]);
      expOp2[l]   = expectedOperand(src2Tag[l]);
      expTag[l]   = issueTag[l];
    end
    @(posedge clk);
    updateModel();
    @(negedge clk);
    cycleCount++;
    if (opValid !== expValid) reportMismatch("opValid", 64'(expValid), 64'(opValid));
    for (int l = 0; l < NUM_LANES; l++) begin
      if (issued[l] && operand1[l] !== expOp1[l]) begin
        reportMismatch($sformatf("operand1[%0d]", l), 64'(expOp1[l]), 64'(operand1[l]));
      end
      if (issued[l] && operand2[l] !== expOp2[l]) begin
        reportMismatch($sformatf("operand2[%0d]", l), 64'(expOp2[l]), 64'(operand2[l]));
      end
      if (issued[l] && opIssueTag[l] !== expTag[l]) begin
        reportMismatch($sformatf("opIssueTag[%0d]", l), 64'(expTag[l]), 64'(opIssueTag[l]));
      end
    end
    if (phyRegRdy !== refRdy) reportMismatch("phyRegRdy", 64'(refRdy), 64'(phyRegRdy));
    idleInputs();
  endtask

  `include "regReadTests.svh"

  initial begin
    idleInputs();
    arstN  = 1'b0;
    refRdy = initialReady();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    checkResetState();
    preloadRegs();
    writeThenRead();
    sameCycleForward();
    mispredictSquash();
    scoreboardUpdates();
    backToBackIssue();
    $display("Errors: %0d over %0d checked cycles", errorCount, cycleCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
verilog/rrPkg.sv
verilog/physRegFile.sv
verilog/operandBypass.sv
verilog/issueSquash.sv
verilog/readyScoreboard.sv
verilog/regReadStage.sv
sim/regReadTb.sv

/* Makefile */
# Verilator build and run for the register-read stage testbench

VERILATOR ?= verilator
TOP       ?= regReadTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test OK

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard sim/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
